//--- flist.f
+incdir+.
rv_isa_pkg.sv
exec_pkg.sv
issue_dispatch.sv
alu_unit.sv
branch_unit.sv
mult_unit.sv
div_unit.sv
execute_stage.sv
tb_clock.sv
execute_stage_tb.sv

//--- exec_ref.svh
// reference model of the integer execute stage for the testbench
// expected result of each unit, operand generator and expected-value queues
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

typedef struct packed {
  exec_pkg::cb_result_t res;
  int                   due;
} expect_t;

logic [31:0] lcg_state = 32'h6e9a_a653;

expect_t             alu_q[$];
expect_t             br_q[$];
expect_t             mul_q[$];
expect_t             div_q[$];
exec_pkg::redirect_t redir_q[$];

// two lcg steps, upper halves only since the low bits repeat quickly
function automatic logic [31:0] rand32();
  logic [15:0] hi;
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  hi = lcg_state[31:16];
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return {hi, lcg_state[31:16]};
endfunction

// corner values show up often
function automatic rv_isa_pkg::word_t pick_operand();
  logic [31:0] r;
  r = rand32();
  case (r[2:0])
    3'd0:    return 32'd0;
    3'd1:    return 32'hffff_ffff;
    3'd2:    return 32'h8000_0000;
    3'd3:    return {28'd0, r[31:28]};
    default: return rand32();
  endcase
endfunction

function automatic rv_isa_pkg::word_t alu_model(exec_pkg::issue_t b);
  logic [4:0] sh;
  sh = b.rs2[4:0];
  case (rv_isa_pkg::alu_op_t'(b.op))
    rv_isa_pkg::ADD:  return b.rs1 + b.rs2;
    rv_isa_pkg::SUB:  return b.rs1 - b.rs2;
    rv_isa_pkg::SLL:  return b.rs1 << sh;
    rv_isa_pkg::SLT:  return ($signed(b.rs1) < $signed(b.rs2)) ? 32'd1 : 32'd0;
    rv_isa_pkg::SLTU: return (b.rs1 < b.rs2) ? 32'd1 : 32'd0;
    rv_isa_pkg::XOR:  return b.rs1 ^ b.rs2;
    rv_isa_pkg::SRL:  return b.rs1 >> sh;
    // logical shift with the vacated bits filled from the sign
    rv_isa_pkg::SRA:  return (b.rs1 >> sh) | (b.rs1[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
    rv_isa_pkg::OR:   return b.rs1 | b.rs2;
    rv_isa_pkg::AND:  return b.rs1 & b.rs2;
    rv_isa_pkg::LINK: return b.pc + 32'd4;
    default:          return 32'd0;
  endcase
endfunction

function automatic logic is_jump(exec_pkg::issue_t b);
  return (b.op == 4'(rv_isa_pkg::JAL)) || (b.op == 4'(rv_isa_pkg::JALR));
endfunction

function automatic logic branch_taken(exec_pkg::issue_t b);
  case (rv_isa_pkg::br_op_t'(b.op))
    rv_isa_pkg::BEQ:  return b.rs1 == b.rs2;
    rv_isa_pkg::BNE:  return b.rs1 != b.rs2;
    rv_isa_pkg::BLT:  return $signed(b.rs1) < $signed(b.rs2);
    rv_isa_pkg::BGE:  return !($signed(b.rs1) < $signed(b.rs2));
    rv_isa_pkg::BLTU: return b.rs1 < b.rs2;
    rv_isa_pkg::BGEU: return !(b.rs1 < b.rs2);
    default:          return 1'b1;
  endcase
endfunction

function automatic exec_pkg::redirect_t branch_redirect(exec_pkg::issue_t b);
  logic                taken;
  rv_isa_pkg::word_t   tgt;
  exec_pkg::redirect_t r;
  taken = branch_taken(b);
  if (b.op == 4'(rv_isa_pkg::JALR)) begin
    tgt = (b.rs1 + b.imm) & 32'hffff_fffe;
  end else begin
    tgt = b.pc + b.imm;
  end
  r.valid  = is_jump(b) || (taken != b.pred_taken);
  r.target = taken ? tgt : b.pc + 32'd4;
  return r;
endfunction

function automatic rv_isa_pkg::word_t mul_model(exec_pkg::issue_t b);
  logic signed [63:0] x;
  logic signed [63:0] y;
  logic        [63:0] p;
  rv_isa_pkg::mul_op_t op;
  op = rv_isa_pkg::mul_op_t'(b.op[1:0]);
  x  = (op == rv_isa_pkg::MULHU) ? {32'd0, b.rs1} : {{32{b.rs1[31]}}, b.rs1};
  y  = (op == rv_isa_pkg::MULHSU || op == rv_isa_pkg::MULHU) ? {32'd0, b.rs2}
                                                              : {{32{b.rs2[31]}}, b.rs2};
  p  = x * y;
  return (op == rv_isa_pkg::MUL) ? p[31:0] : p[63:32];
endfunction

function automatic rv_isa_pkg::word_t div_model(exec_pkg::issue_t b);
  rv_isa_pkg::div_op_t op;
  logic                want_rem;
  logic                sgn;
  op       = rv_isa_pkg::div_op_t'(b.op[1:0]);
  want_rem = (op == rv_isa_pkg::REM) || (op == rv_isa_pkg::REMU);
  sgn      = (op == rv_isa_pkg::DIV) || (op == rv_isa_pkg::REM);
  if (b.rs2 == 32'd0) begin
    return want_rem ? b.rs1 : 32'hffff_ffff;
  end
  if (sgn && b.rs1 == 32'h8000_0000 && b.rs2 == 32'hffff_ffff) begin
    return want_rem ? 32'd0 : b.rs1;
  end
  if (sgn) begin
    return want_rem ? $signed(b.rs1) % $signed(b.rs2) : $signed(b.rs1) / $signed(b.rs2);
  end
  return want_rem ? b.rs1 % b.rs2 : b.rs1 / b.rs2;
endfunction

`endif

//--- execute_stage_tb.sv
// testbench for the integer execute stage
// random issue traffic per unit and mixed, results checked against the
// reference model with exact latency on every completion port
`timescale 1ns/1ps

module execute_stage_tb;

  localparam int MUL_LATENCY     = 3;
  localparam int N_ALU           = 200;
  localparam int N_BR_EACH       = 16;
  localparam int N_JUMP          = 12;
  localparam int N_MUL           = 64;
  localparam int N_DIV_ROUNDS    = 12;
  localparam int N_MIX           = 300;
  localparam int N_TOTAL         = N_ALU + 6 * N_BR_EACH + 2 * N_JUMP + N_MUL
                                   + 4 * N_DIV_ROUNDS + N_MIX;
  localparam int WATCHDOG_CYCLES = N_TOTAL * 40 + 200;

  logic                          CLK;
  logic                          nRST;
  exec_pkg::issue_t              issue;
  logic                          issue_ready;
  exec_pkg::cb_result_t          alu_done;
  exec_pkg::cb_result_t          br_done;
  exec_pkg::cb_result_t          mul_done;
  exec_pkg::cb_result_t          div_done;
  exec_pkg::redirect_t           redirect;
  int                            cycle = 0;
  int                            error_count = 0;
  logic [exec_pkg::CB_IDX_W-1:0] next_idx = '0;

  `include "exec_ref.svh"

  tb_clock #(
    .PERIOD_NS    (4),
    .RESET_CYCLES (8)
  ) u_clock (
    .CLK  (CLK),
    .nRST (nRST)
  );

  execute_stage #(
    .MUL_LATENCY (MUL_LATENCY)
  ) DUT (
    .CLK         (CLK),
    .nRST        (nRST),
    .issue       (issue),
    .issue_ready (issue_ready),
    .alu_done    (alu_done),
    .br_done     (br_done),
    .mul_done    (mul_done),
    .div_done    (div_done),
    .redirect    (redirect)
  );

  always @(posedge CLK) begin
    cycle <= cycle + 1;
  end

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic plain_error(input string msg);
    error_count++;
    $display("%s (time %0t)", msg, $time);
    abort_run();
  endtask

  task automatic value_error(input string sig, input logic [31:0] got, input logic [31:0] want);
    error_count++;
    $display("Error at %0t: %s is %h, expected %h", $time, sig, got, want);
    abort_run();
  endtask

  function automatic exec_pkg::issue_t make_issue(input exec_pkg::unit_t u, input logic [3:0] op);
    exec_pkg::issue_t b;
    logic [31:0]      r;
    r            = rand32();
    b.valid      = 1'b1;
    b.unit       = u;
    b.op         = op;
    b.rs1        = pick_operand();
    b.rs2        = pick_operand();
    b.imm        = rand32();
    b.pc         = rand32() & 32'hffff_fffc;
    b.rd         = r[4:0];
    b.pred_taken = r[8];
    b.idx        = next_idx;
    next_idx     = next_idx + 3'd1;
    return b;
  endfunction

  task automatic record_expected(input exec_pkg::issue_t b);
    expect_t e;
    e.res.valid = 1'b1;
    e.res.wen   = 1'b1;
    e.res.rd    = b.rd;
    e.res.idx   = b.idx;
    e.res.data  = 32'd0;
    case (b.unit)
      exec_pkg::U_ALU: begin
        e.res.data = alu_model(b);
        e.due      = cycle + 1;
        alu_q.push_back(e);
      end
      exec_pkg::U_BR: begin
        e.res.wen  = is_jump(b);
        e.res.data = b.pc + 32'd4;
        e.due      = cycle + 1;
        br_q.push_back(e);
        redir_q.push_back(branch_redirect(b));
      end
      exec_pkg::U_MUL: begin
        e.res.data = mul_model(b);
        e.due      = cycle + MUL_LATENCY;
        mul_q.push_back(e);
      end
      default: begin
        // zero divisor finishes at once, otherwise 32 steps and the result
        e.res.data = div_model(b);
        e.due      = cycle + ((b.rs2 == 32'd0) ? 1 : 33);
        div_q.push_back(e);
      end
    endcase
  endtask

  // called at a falling edge, returns at the falling edge after acceptance
  task automatic issue_one(input exec_pkg::issue_t b, output int stalls);
    logic accepted;
    stalls   = 0;
    accepted = 1'b0;
    issue    = b;
    while (!accepted) begin
      #1;
      if (issue_ready === 1'b1) begin
        record_expected(b);
        accepted = 1'b1;
      end else begin
        stalls++;
      end
      @(negedge CLK);
    end
    issue.valid = 1'b0;
  endtask

  task automatic idle_cycle();
    issue.valid = 1'b0;
    @(negedge CLK);
  endtask

  task automatic compare_result(input string name, input exec_pkg::cb_result_t got,
                                input expect_t want);
    assert (cycle == want.due)
      else plain_error($sformatf("%s result came in cycle %0d instead of cycle %0d",
                                 name, cycle, want.due));
    assert (got.wen === want.res.wen)
      else value_error({name, ".wen"}, 32'(got.wen), 32'(want.res.wen));
    assert (got.rd === want.res.rd)
      else value_error({name, ".rd"}, 32'(got.rd), 32'(want.res.rd));
    assert (got.idx === want.res.idx)
      else value_error({name, ".idx"}, 32'(got.idx), 32'(want.res.idx));
    if (want.res.wen) begin
      assert (got.data === want.res.data)
        else value_error({name, ".data"}, got.data, want.res.data);
    end
  endtask

  task automatic check_redirect(input exec_pkg::redirect_t want);
    assert (redirect.valid === want.valid)
      else value_error("redirect.valid", 32'(redirect.valid), 32'(want.valid));
    if (want.valid) begin
      assert (redirect.target === want.target)
        else value_error("redirect.target", redirect.target, want.target);
    end
  endtask

  // registered outputs are sampled on the falling edge
  initial begin
    forever begin
      @(negedge CLK);
      if (alu_done.valid === 1'b1) begin
        if (alu_q.size() == 0) plain_error("alu_done went valid with no result expected");
        else compare_result("alu_done", alu_done, alu_q.pop_front());
      end
      if (br_done.valid === 1'b1) begin
        if (br_q.size() == 0) begin
          plain_error("br_done went valid with no result expected");
        end else begin
          compare_result("br_done", br_done, br_q.pop_front());
          check_redirect(redir_q.pop_front());
        end
      end else if (redirect.valid === 1'b1) begin
        plain_error("redirect went valid without a branch result");
      end
      if (mul_done.valid === 1'b1) begin
        if (mul_q.size() == 0) plain_error("mul_done went valid with no result expected");
        else compare_result("mul_done", mul_done, mul_q.pop_front());
      end
      if (div_done.valid === 1'b1) begin
        if (div_q.size() == 0) plain_error("div_done went valid with no result expected");
        else compare_result("div_done", div_done, div_q.pop_front());
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    plain_error($sformatf("watchdog expired after %0d cycles, the run did not finish",
                          WATCHDOG_CYCLES));
  end

  initial begin
    exec_pkg::issue_t b;
    logic [31:0]      r;
    int               stalls;
    issue = '0;
    wait (nRST === 1'b1);
    @(negedge CLK);
    assert (issue_ready === 1'b1) else value_error("issue_ready", 32'(issue_ready), 32'd1);
    assert ({alu_done.valid, br_done.valid, mul_done.valid, div_done.valid,
             redirect.valid} === 5'b0)
      else plain_error("a completion or redirect is valid right after reset");

    for (int i = 0; i < N_ALU; i++) begin
      issue_one(make_issue(exec_pkg::U_ALU, 4'(i % 11)), stalls);
    end

    // conditional branches, then both jump kinds
    for (int op = 0; op < 6; op++) begin
      for (int i = 0; i < N_BR_EACH; i++) begin
        issue_one(make_issue(exec_pkg::U_BR, 4'(op)), stalls);
      end
    end
    for (int i = 0; i < 2 * N_JUMP; i++) begin
      b = make_issue(exec_pkg::U_BR, (i < N_JUMP) ? 4'(rv_isa_pkg::JAL) : 4'(rv_isa_pkg::JALR));
      issue_one(b, stalls);
    end

    // one multiply per cycle
    for (int i = 0; i < N_MUL; i++) begin
      issue_one(make_issue(exec_pkg::U_MUL, 4'(i % 4)), stalls);
    end

    // long divide, side traffic, then a divide that has to wait
    for (int i = 0; i < N_DIV_ROUNDS; i++) begin
      b = make_issue(exec_pkg::U_DIV, 4'(rand32() % 32'd4));
      if (b.rs2 == 32'd0) begin
        b.rs2 = 32'd7;
      end
      issue_one(b, stalls);
      issue_one(make_issue(exec_pkg::U_ALU, 4'(i % 11)), stalls);
      assert (stalls == 0) else plain_error("arithmetic op was held while the divider ran");
      issue_one(make_issue(exec_pkg::U_MUL, 4'(i % 4)), stalls);
      assert (stalls == 0) else plain_error("multiply was held while the divider ran");
      b = make_issue(exec_pkg::U_DIV, 4'(i % 4));
      if (i % 3 == 0) begin
        b.rs2 = 32'd0;
      end else if (i % 3 == 1) begin
        b.rs1 = 32'h8000_0000;
        b.rs2 = 32'hffff_ffff;
      end
      issue_one(b, stalls);
      assert (stalls > 0) else plain_error("second divide was not held by the busy divider");
    end

    for (int i = 0; i < N_MIX; i++) begin
      r = rand32();
      case (r[1:0])
        2'd0:    b = make_issue(exec_pkg::U_ALU, 4'(r[31:8] % 24'd11));
        2'd1:    b = make_issue(exec_pkg::U_BR, {1'b0, r[10:8]});
        2'd2:    b = make_issue(exec_pkg::U_MUL, {2'b00, r[9:8]});
        default: b = make_issue(exec_pkg::U_DIV, {2'b00, r[9:8]});
      endcase
      issue_one(b, stalls);
      if (r[15:12] == 4'd0) begin
        idle_cycle();
      end
    end

    idle_cycle();
    while (alu_q.size() + br_q.size() + mul_q.size() + div_q.size() != 0) begin
      @(negedge CLK);
    end
    // quiet tail to catch stray completions
    repeat (40) @(negedge CLK);
    assert (redir_q.size() == 0) else plain_error("expected redirects were left unchecked");

    if (error_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

//--- tb_clock.sv
// clock and reset source for the execute stage testbench
// free running clock, active low reset held for a number of cycles
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 8
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever begin
      #(PERIOD_NS / 2) CLK = ~CLK;
    end
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

//--- execute_stage.sv
// integer execute stage
// dispatch feeding the arithmetic, branch, multiply and divide units,
// each unit with its own completion port
`timescale 1ns/1ps

module execute_stage #(
  parameter int MUL_LATENCY = 3
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  exec_pkg::issue_t     issue,
  output logic                 issue_ready,
  output exec_pkg::cb_result_t alu_done,
  output exec_pkg::cb_result_t br_done,
  output exec_pkg::cb_result_t mul_done,
  output exec_pkg::cb_result_t div_done,
  output exec_pkg::redirect_t  redirect
);

  logic alu_start;
  logic br_start;
  logic mul_start;
  logic div_start;
  logic div_busy;

  issue_dispatch u_dispatch (
    .issue       (issue),
    .div_busy    (div_busy),
    .issue_ready (issue_ready),
    .alu_start   (alu_start),
    .br_start    (br_start),
    .mul_start   (mul_start),
    .div_start   (div_start)
  );

  alu_unit u_alu (
    .CLK       (CLK),
    .nRST      (nRST),
    .issue     (issue),
    .alu_start (alu_start),
    .alu_done  (alu_done)
  );

  branch_unit u_branch (
    .CLK      (CLK),
    .nRST     (nRST),
    .issue    (issue),
    .br_start (br_start),
    .br_done  (br_done),
    .redirect (redirect)
  );

  mult_unit #(
    .MUL_LATENCY (MUL_LATENCY)
  ) u_mult (
    .CLK       (CLK),
    .nRST      (nRST),
    .issue     (issue),
    .mul_start (mul_start),
    .mul_done  (mul_done)
  );

  div_unit u_div (
    .CLK       (CLK),
    .nRST      (nRST),
    .issue     (issue),
    .div_start (div_start),
    .div_busy  (div_busy),
    .div_done  (div_done)
  );

endmodule

//--- div_unit.sv
// iterative restoring divider
// 32 shift-subtract steps on magnitudes with a final sign fix,
// zero divisor finishes the cycle after issue
`timescale 1ns/1ps

module div_unit (
  input  logic                 CLK,
  input  logic                 nRST,
  input  exec_pkg::issue_t     issue,
  input  logic                 div_start,
  output logic                 div_busy,
  output exec_pkg::cb_result_t div_done
);

  rv_isa_pkg::div_op_t           op;
  logic                          is_signed;
  logic                          is_rem_in;
  logic                          neg_a;
  logic                          neg_b;
  rv_isa_pkg::word_t             mag_a;
  rv_isa_pkg::word_t             mag_b;
  rv_isa_pkg::word_t             dvsr;
  rv_isa_pkg::word_t             rem;
  rv_isa_pkg::word_t             quo;
  rv_isa_pkg::word_t             step_rem;
  rv_isa_pkg::word_t             step_quo;
  rv_isa_pkg::word_t             q_fix;
  rv_isa_pkg::word_t             r_fix;
  logic [32:0]                   rem_shift;
  logic [32:0]                   diff;
  logic [4:0]                    cnt;
  logic                          busy;
  logic                          last_step;
  logic                          neg_q;
  logic                          neg_r;
  logic                          is_rem;
  logic [4:0]                    rd_q;
  logic [exec_pkg::CB_IDX_W-1:0] idx_q;

  assign op        = rv_isa_pkg::div_op_t'(issue.op[1:0]);
  assign is_signed = (op == rv_isa_pkg::DIV) || (op == rv_isa_pkg::REM);
  assign is_rem_in = (op == rv_isa_pkg::REM) || (op == rv_isa_pkg::REMU);
  assign neg_a     = is_signed & issue.rs1[31];
  assign neg_b     = is_signed & issue.rs2[31];
  assign mag_a     = neg_a ? -issue.rs1 : issue.rs1;
  assign mag_b     = neg_b ? -issue.rs2 : issue.rs2;

  // bit 32 of diff set means the trial subtract underflowed
  assign rem_shift = {rem, quo[31]};
  assign diff      = rem_shift - {1'b0, dvsr};
  assign step_rem  = diff[32] ? rem_shift[31:0] : diff[31:0];
  assign step_quo  = {quo[30:0], ~diff[32]};

  // remainder follows the dividend sign
  assign q_fix = neg_q ? -step_quo : step_quo;
  assign r_fix = neg_r ? -step_rem : step_rem;

  assign last_step = (cnt == 5'd31);
  assign div_busy  = busy;

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      busy     <= 1'b0;
      cnt      <= '0;
      div_done <= '0;
    end else begin
      div_done.valid <= 1'b0;
      if (div_start) begin
        cnt <= '0;
        if (issue.rs2 == '0) begin
          div_done.valid <= 1'b1;
          div_done.wen   <= 1'b1;
          div_done.rd    <= issue.rd;
          div_done.idx   <= issue.idx;
          div_done.data  <= is_rem_in ? issue.rs1 : {32{1'b1}};
        end else begin
          busy <= 1'b1;
        end
      end else if (busy) begin
        if (last_step) begin
          // busy drops with the result so a new divide can issue now
          busy           <= 1'b0;
          div_done.valid <= 1'b1;
          div_done.wen   <= 1'b1;
          div_done.rd    <= rd_q;
          div_done.idx   <= idx_q;
          div_done.data  <= is_rem ? r_fix : q_fix;
        end else begin
          cnt <= cnt + 5'd1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (div_start) begin
      dvsr   <= mag_b;
      quo    <= mag_a;
      rem    <= '0;
      neg_q  <= neg_a ^ neg_b;
      neg_r  <= neg_a;
      is_rem <= is_rem_in;
      rd_q   <= issue.rd;
      idx_q  <= issue.idx;
    end else if (busy) begin
      rem <= step_rem;
      quo <= step_quo;
    end
  end

endmodule

//--- mult_unit.sv
// pipelined 32x32 multiplier
// product formed in the first stage, then carried with its tag through
// MUL_LATENCY registered stages, one new multiply per cycle
`timescale 1ns/1ps

module mult_unit #(
  parameter int MUL_LATENCY = 3
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  exec_pkg::issue_t     issue,
  input  logic                 mul_start,
  output exec_pkg::cb_result_t mul_done
);

  typedef struct packed {
    logic                          hi;
    logic [4:0]                    rd;
    logic [exec_pkg::CB_IDX_W-1:0] idx;
    logic [63:0]                   prod;
  } mul_stage_t;

  rv_isa_pkg::mul_op_t op;
  logic                sign_a;
  logic                sign_b;
  logic signed [32:0]  a_ext;
  logic signed [32:0]  b_ext;
  logic signed [65:0]  prod_full;
  mul_stage_t          first;
  mul_stage_t          pipe [MUL_LATENCY];
  logic [MUL_LATENCY-1:0] vld;

  assign op = rv_isa_pkg::mul_op_t'(issue.op[1:0]);

  // mulhsu treats rs2 as unsigned, mulhu both
  assign sign_a = (op != rv_isa_pkg::MULHU);
  assign sign_b = (op == rv_isa_pkg::MUL) || (op == rv_isa_pkg::MULH);
  assign a_ext  = {sign_a & issue.rs1[31], issue.rs1};
  assign b_ext  = {sign_b & issue.rs2[31], issue.rs2};

  assign prod_full = a_ext * b_ext;

  assign first.hi   = (op != rv_isa_pkg::MUL);
  assign first.rd   = issue.rd;
  assign first.idx  = issue.idx;
  assign first.prod = prod_full[63:0];

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      vld <= '0;
    end else begin
      vld <= {vld[MUL_LATENCY-2:0], mul_start};
    end
  end

  always_ff @(posedge CLK) begin
    if (mul_start) begin
      pipe[0] <= first;
    end
    for (int i = 1; i < MUL_LATENCY; i++) begin
      pipe[i] <= pipe[i-1];
    end
  end

  assign mul_done.valid = vld[MUL_LATENCY-1];
  assign mul_done.wen   = 1'b1;
  assign mul_done.rd    = pipe[MUL_LATENCY-1].rd;
  assign mul_done.idx   = pipe[MUL_LATENCY-1].idx;
  assign mul_done.data  = pipe[MUL_LATENCY-1].hi ? pipe[MUL_LATENCY-1].prod[63:32]
                                                 : pipe[MUL_LATENCY-1].prod[31:0];

endmodule

//--- branch_unit.sv
// branch resolution unit
// evaluates the condition and target, compares against the prediction
// and sends a redirect on jumps and mispredicts
`timescale 1ns/1ps

module branch_unit (
  input  logic                 CLK,
  input  logic                 nRST,
  input  exec_pkg::issue_t     issue,
  input  logic                 br_start,
  output exec_pkg::cb_result_t br_done,
  output exec_pkg::redirect_t  redirect
);

  rv_isa_pkg::br_op_t op;
  rv_isa_pkg::word_t  a;
  rv_isa_pkg::word_t  b;
  rv_isa_pkg::word_t  pc4;
  rv_isa_pkg::word_t  jalr_sum;
  rv_isa_pkg::word_t  target;
  logic               taken;
  logic               is_jump;
  logic               mispredict;

  assign op = rv_isa_pkg::br_op_t'(issue.op);
  assign a  = issue.rs1;
  assign b  = issue.rs2;

  always_comb begin
    case (op)
      rv_isa_pkg::BEQ:  taken = (a == b);
      rv_isa_pkg::BNE:  taken = (a != b);
      rv_isa_pkg::BLT:  taken = ($signed(a) < $signed(b));
      rv_isa_pkg::BGE:  taken = ($signed(a) >= $signed(b));
      rv_isa_pkg::BLTU: taken = (a < b);
      rv_isa_pkg::BGEU: taken = (a >= b);
      rv_isa_pkg::JAL,
      rv_isa_pkg::JALR: taken = 1'b1;
      default:          taken = 1'b0;
    endcase
  end

  assign is_jump  = (op == rv_isa_pkg::JAL) || (op == rv_isa_pkg::JALR);
  assign pc4      = issue.pc + 32'd4;
  assign jalr_sum = issue.rs1 + issue.imm;
  // jalr clears bit 0 of the sum
  assign target   = (op == rv_isa_pkg::JALR) ? {jalr_sum[31:1], 1'b0} : issue.pc + issue.imm;

  assign mispredict = ~is_jump & (taken ^ issue.pred_taken);

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      br_done  <= '0;
      redirect <= '0;
    end else begin
      br_done.valid  <= br_start;
      redirect.valid <= br_start & (is_jump | mispredict);
      if (br_start) begin
        br_done.wen     <= is_jump;
        br_done.rd      <= issue.rd;
        br_done.idx     <= issue.idx;
        br_done.data    <= pc4;
        // not taken only matters for a branch predicted taken
        redirect.target <= taken ? target : pc4;
      end
    end
  end

endmodule

//--- alu_unit.sv
// integer arithmetic unit
// single cycle ops plus the jump link value, result registered
// onto its own completion port
`timescale 1ns/1ps

module alu_unit (
  input  logic                 CLK,
  input  logic                 nRST,
  input  exec_pkg::issue_t     issue,
  input  logic                 alu_start,
  output exec_pkg::cb_result_t alu_done
);

  rv_isa_pkg::alu_op_t op;
  rv_isa_pkg::word_t   a;
  rv_isa_pkg::word_t   b;
  rv_isa_pkg::word_t   res;
  logic [4:0]          shamt;

  assign op    = rv_isa_pkg::alu_op_t'(issue.op);
  assign a     = issue.rs1;
  assign b     = issue.rs2;
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv_isa_pkg::ADD:  res = a + b;
      rv_isa_pkg::SUB:  res = a - b;
      rv_isa_pkg::SLL:  res = a << shamt;
      rv_isa_pkg::SLT:  res = {31'd0, $signed(a) < $signed(b)};
      rv_isa_pkg::SLTU: res = {31'd0, a < b};
      rv_isa_pkg::XOR:  res = a ^ b;
      rv_isa_pkg::SRL:  res = a >> shamt;
      rv_isa_pkg::SRA:  res = rv_isa_pkg::word_t'($signed(a) >>> shamt);
      rv_isa_pkg::OR:   res = a | b;
      rv_isa_pkg::AND:  res = a & b;
      // return address of a jump
      rv_isa_pkg::LINK: res = issue.pc + 32'd4;
      default:          res = '0;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      alu_done <= '0;
    end else begin
      alu_done.valid <= alu_start;
      if (alu_start) begin
        alu_done.wen  <= 1'b1;
        alu_done.rd   <= issue.rd;
        alu_done.idx  <= issue.idx;
        alu_done.data <= res;
      end
    end
  end

endmodule

//--- issue_dispatch.sv
// issue dispatch for the integer execute stage
// accepts one bundle per cycle and raises the start strobe of its unit,
// holding back divides while the divider is occupied
`timescale 1ns/1ps

module issue_dispatch (
  input  exec_pkg::issue_t issue,
  input  logic             div_busy,
  output logic             issue_ready,
  output logic             alu_start,
  output logic             br_start,
  output logic             mul_start,
  output logic             div_start
);

  logic [3:0] sel;
  logic       div_blocked;
  logic       accept;

  // one-hot unit select
  always_comb begin
    sel = 4'b0000;
    case (issue.unit)
      exec_pkg::U_ALU: sel[0] = 1'b1;
      exec_pkg::U_BR:  sel[1] = 1'b1;
      exec_pkg::U_MUL: sel[2] = 1'b1;
      exec_pkg::U_DIV: sel[3] = 1'b1;
      default:         sel    = 4'b0000;
    endcase
  end

  // only a waiting divide is stalled, other units keep flowing
  assign div_blocked = issue.valid & sel[3] & div_busy;
  assign issue_ready = ~div_blocked;

  assign accept = issue.valid & issue_ready;

  assign alu_start = accept & sel[0];
  assign br_start  = accept & sel[1];
  assign mul_start = accept & sel[2];
  assign div_start = accept & sel[3];

endmodule

//--- exec_pkg.sv
// execute stage transport types
// issue bundle from dispatch, completion results and branch redirect
package exec_pkg;

  // completion buffer has 8 entries
  parameter int CB_IDX_W = 3;

  typedef enum logic [1:0] {
    U_ALU = 2'd0,
    U_BR  = 2'd1,
    U_MUL = 2'd2,
    U_DIV = 2'd3
  } unit_t;

  // one tagged instruction, op is read as the enum of its unit group
  typedef struct packed {
    logic                  valid;
    unit_t                 unit;
    logic [3:0]            op;
    rv_isa_pkg::word_t     rs1;
    rv_isa_pkg::word_t     rs2;
    rv_isa_pkg::word_t     imm;
    rv_isa_pkg::word_t     pc;
    logic [4:0]            rd;
    logic [CB_IDX_W-1:0]   idx;
    logic                  pred_taken;
  } issue_t;

  // result written into the completion buffer entry idx
  typedef struct packed {
    logic                  valid;
    logic                  wen;
    logic [4:0]            rd;
    logic [CB_IDX_W-1:0]   idx;
    rv_isa_pkg::word_t     data;
  } cb_result_t;

  // fetch redirect on a jump or a mispredicted branch
  typedef struct packed {
    logic                  valid;
    rv_isa_pkg::word_t     target;
  } redirect_t;

endpackage

//--- rv_isa_pkg.sv
// RV32 integer ISA types used by the execute units
// data word and the operation codes of each unit group
package rv_isa_pkg;

  parameter int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  // arithmetic group, LINK writes pc + 4
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    SLL  = 4'd2,
    SLT  = 4'd3,
    SLTU = 4'd4,
    XOR  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    OR   = 4'd8,
    AND  = 4'd9,
    LINK = 4'd10
  } alu_op_t;

  // conditional branches and jumps
  typedef enum logic [3:0] {
    BEQ  = 4'd0,
    BNE  = 4'd1,
    BLT  = 4'd2,
    BGE  = 4'd3,
    BLTU = 4'd4,
    BGEU = 4'd5,
    JAL  = 4'd6,
    JALR = 4'd7
  } br_op_t;

  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mul_op_t;

  typedef enum logic [1:0] {
    DIV  = 2'd0,
    DIVU = 2'd1,
    REM  = 2'd2,
    REMU = 2'd3
  } div_op_t;

endpackage
